// File: source/wiscPkg.sv
/* Types and instruction encodings shared by the WISC core and its model
   LD, ST, STU, SIIC and RTI have no constants here and decode as NOP */
package wiscPkg;

   // Data word and byte address
   typedef logic [15:0] word;
   typedef logic [2:0] regIdx;
   typedef logic [4:0] opcode;

   // Instruction memory depth in words, as a power of two
   parameter int instrDepthLog2 = 8;

   // Shift group codes follow the funct field and the low opcode bits
   typedef enum logic [2:0] {
      aluRol  = 3'b000,
      aluSll  = 3'b001,
      aluRor  = 3'b010,
      aluSrl  = 3'b011,
      aluAdd  = 3'b100,
      aluAndn = 3'b101,
      aluXor  = 3'b110
   } aluOp;

   // Control and jumps
   localparam opcode opHalt  = 5'b00000;
   localparam opcode opNop   = 5'b00001;
   localparam opcode opJ     = 5'b00100;
   localparam opcode opJr    = 5'b00101;
   localparam opcode opJal   = 5'b00110;
   localparam opcode opJalr  = 5'b00111;

   // 5-bit immediate arithmetic
   localparam opcode opAddi  = 5'b01000;
   localparam opcode opSubi  = 5'b01001;
   localparam opcode opXori  = 5'b01010;
   localparam opcode opAndni = 5'b01011;

   // Branches test Rs against zero
   localparam opcode opBeqz  = 5'b01100;
   localparam opcode opBnez  = 5'b01101;
   localparam opcode opBltz  = 5'b01110;
   localparam opcode opBgez  = 5'b01111;

   // Immediate shifts and rotates
   localparam opcode opSlbi  = 5'b10010;
   localparam opcode opRoli  = 5'b10100;
   localparam opcode opSlli  = 5'b10101;
   localparam opcode opRori  = 5'b10110;
   localparam opcode opSrli  = 5'b10111;

   // Register formats
   localparam opcode opLbi   = 5'b11000;
   localparam opcode opBtr   = 5'b11001;
   localparam opcode opShift = 5'b11010;
   localparam opcode opAlu   = 5'b11011;
   localparam opcode opSeq   = 5'b11100;
   localparam opcode opSlt   = 5'b11101;
   localparam opcode opSle   = 5'b11110;
   localparam opcode opSco   = 5'b11111;

   // Function field of opAlu
   localparam logic [1:0] fnAdd  = 2'b00;
   localparam logic [1:0] fnSub  = 2'b01;
   localparam logic [1:0] fnXor  = 2'b10;
   localparam logic [1:0] fnAndn = 2'b11;

   // Function field of opShift
   localparam logic [1:0] fnRol  = 2'b00;
   localparam logic [1:0] fnSll  = 2'b01;
   localparam logic [1:0] fnRor  = 2'b10;
   localparam logic [1:0] fnSrl  = 2'b11;

endpackage

// File: source/instrMem.sv
/* Instruction store with one write port for loading and one read port
   The array has no reset and reads back X until a word is written */
`timescale 1ns/100ps

module instrMem import wiscPkg::*; #(
   parameter int instrDepthLog2 = wiscPkg::instrDepthLog2
) (
   input  logic                      clk,
   input  logic                      instrWr,
   input  logic [instrDepthLog2-1:0] instrWrAddr,
   input  word                       instrWrData,
   input  logic [instrDepthLog2-1:0] rdAddr,
   output word                       rdData
);

   // One word per instruction
   word mem [2**instrDepthLog2];

   // Loader writes on the clock edge
   always_ff @(posedge clk) begin
      if (instrWr) begin
         mem[instrWrAddr] <= instrWrData;
      end
   end

   // Fetch path is combinational
   assign rdData = mem[rdAddr];

endmodule

// File: source/decode.sv
/* Combinational decode of one WISC instruction into execute controls
   Unsupported opcodes come out as NOP with no write-back */
`timescale 1ns/100ps

module decode import wiscPkg::*; (
   input  word   instr,
   output regIdx rs,
   output regIdx rt,
   output regIdx rd,
   output word   imm,
   output logic  wbEn,
   output logic  immPres,
   output logic  aluSrc,
   output logic  slbi,
   output logic  btr,
   output logic  sl,
   output logic  seq,
   output logic  sco,
   output logic  invA,
   output logic  invB,
   output logic  jump,
   output logic  branch,
   output logic  immCtl,
   output logic  link,
   output logic  halt,
   output aluOp  op
);

   opcode opc;
   logic [1:0] funct;
   word imm5s, imm5z, imm8s, imm8z, disp11;

   assign opc = instr[15:11];
   assign funct = instr[1:0];

   // Source fields sit at fixed places in every format
   assign rs = instr[10:8];
   assign rt = instr[7:5];

   // Immediate candidates
   assign imm5s = {{11{instr[4]}}, instr[4:0]};
   assign imm5z = {11'b0, instr[4:0]};
   assign imm8s = {{8{instr[7]}}, instr[7:0]};
   assign imm8z = {8'b0, instr[7:0]};
   assign disp11 = {{5{instr[10]}}, instr[10:0]};

   always_comb begin
      // Defaults give a NOP with an R-format destination
      rd = instr[4:2];
      imm = imm5s;
      wbEn = 1'b0;
      immPres = 1'b0;
      aluSrc = 1'b0;
      slbi = 1'b0;
      btr = 1'b0;
      sl = 1'b0;
      seq = 1'b0;
      sco = 1'b0;
      invA = 1'b0;
      invB = 1'b0;
      jump = 1'b0;
      branch = 1'b0;
      immCtl = 1'b0;
      link = 1'b0;
      halt = 1'b0;
      op = aluAdd;
      case (opc)
         opAddi, opSubi: begin
            rd = instr[7:5];
            wbEn = 1'b1;
            aluSrc = 1'b1;
            // SUBI computes imm - Rs
            invA = (opc == opSubi);
         end
         opXori, opAndni: begin
            rd = instr[7:5];
            wbEn = 1'b1;
            aluSrc = 1'b1;
            imm = imm5z;
            op = (opc == opXori) ? aluXor : aluAndn;
            invB = (opc == opAndni);
         end
         opRoli, opSlli, opRori, opSrli: begin
            rd = instr[7:5];
            wbEn = 1'b1;
            aluSrc = 1'b1;
            imm = imm5z;
            op = aluOp'({1'b0, opc[1:0]});
         end
         opAlu: begin
            wbEn = 1'b1;
            case (funct)
               fnAdd: op = aluAdd;
               fnSub: invA = 1'b1;  // Rt - Rs
               fnXor: op = aluXor;
               default: begin
                  op = aluAndn;
                  invB = 1'b1;
               end
            endcase
         end
         opShift: begin
            wbEn = 1'b1;
            op = aluOp'({1'b0, funct});
         end
         opSeq, opSlt, opSle: begin
            // Compare through Rt - Rs, SLE asks for both less and equal
            wbEn = 1'b1;
            invA = 1'b1;
            seq = (opc != opSlt);
            sl = (opc != opSeq);
         end
         opSco: begin
            wbEn = 1'b1;
            sco = 1'b1;
         end
         opBtr: begin
            wbEn = 1'b1;
            btr = 1'b1;
         end
         opLbi, opSlbi: begin
            // 8-bit loads write back into the Rs field
            rd = instr[10:8];
            wbEn = 1'b1;
            aluSrc = 1'b1;
            immPres = 1'b1;
            slbi = (opc == opSlbi);
            imm = (opc == opSlbi) ? imm8z : imm8s;
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            // Equal or negative test, odd opcodes negate it
            branch = 1'b1;
            imm = imm8s;
            seq = ~opc[1];
            sl = opc[1];
            invB = opc[0];
         end
         opJ, opJr, opJal, opJalr: begin
            // Odd opcodes add to Rs, opc[1] marks the linking forms
            rd = 3'd7;
            jump = 1'b1;
            immCtl = opc[0];
            imm = opc[0] ? imm8s : disp11;
            link = opc[1];
            wbEn = opc[1];
         end
         opHalt: halt = 1'b1;
         default: ;
      endcase
   end

endmodule

// File: source/regFile.sv
/* Eight 16-bit registers with two read ports and one write port
   No write-to-read bypass so a write shows after the clock edge */
`timescale 1ns/100ps

module regFile import wiscPkg::*; (
   input  logic  clk,
   input  logic  arstN,
   input  regIdx rdIdx1,
   input  regIdx rdIdx2,
   output word   rdData1,
   output word   rdData2,
   input  logic  wrEn,
   input  regIdx wrIdx,
   input  word   wrData
);

   word regs [8];

   // All registers start at zero
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrIdx] <= wrData;
      end
   end

   // Reads are combinational
   assign rdData1 = regs[rdIdx1];
   assign rdData2 = regs[rdIdx2];

endmodule

// File: source/alu.sv
/* 16-bit ALU with optional inversion of each input before the operation
   Shift amount is inB[3:0] and ofl is signed overflow of the add only */
`timescale 1ns/100ps

module alu import wiscPkg::*; (
   input  word  inA,
   input  word  inB,
   input  aluOp op,
   input  logic invA,
   input  logic invB,
   output word  result,
   output logic zero,
   output logic ofl
);

   word a, b, sum;
   logic [3:0] amt;
   logic [31:0] rolPair, rorPair;

   // Conditioned operands
   assign a = invA ? ~inA : inA;
   assign b = invB ? ~inB : inB;
   assign amt = inB[3:0];

   // Inverting A with a carry in of one negates it, giving b - A
   assign sum = a + b + {15'b0, invA};

   // Rotates shift a doubled copy and keep one half
   assign rolPair = {a, a} << amt;
   assign rorPair = {a, a} >> amt;

   always_comb begin
      case (op)
         aluRol:  result = rolPair[31:16];
         aluSll:  result = a << amt;
         aluRor:  result = rorPair[15:0];
         aluSrl:  result = a >> amt;
         aluAndn: result = a & b;  // Not of B comes from invB
         aluXor:  result = a ^ b;
         default: result = sum;
      endcase
   end

   assign zero = (result == '0);

   // Like-signed operands with a sum of the other sign
   assign ofl = (op == aluAdd) & (a[15] == b[15]) & (sum[15] != a[15]);

endmodule

// File: source/execute.sv
/* Execute stage with operand select, set and bit-reverse results and next PC
   Branch and jump offsets arrive already sign-extended on imm */
`timescale 1ns/100ps

module execute import wiscPkg::*; (
   input  word  regData1,
   input  word  regData2,
   input  word  imm,
   input  word  pcPlus2,
   input  logic immPres,
   input  logic aluSrc,
   input  logic slbi,
   input  logic btr,
   input  logic sl,
   input  logic seq,
   input  logic sco,
   input  logic invA,
   input  logic invB,
   input  logic jump,
   input  logic branch,
   input  logic immCtl,
   input  aluOp op,
   output word  result,
   output word  nextPc
);

   word inA, inB, aluOut, bitRev, target;
   logic zero, ofl, lessThan, carry, setBit, taken;

   // LBI adds to zero and SLBI adds under the shifted Rs
   assign inA = immPres ? (slbi ? (regData1 << 8) : '0) : regData1;
   assign inB = aluSrc ? imm : regData2;

   alu executeAlu (
      .inA(inA),
      .inB(inB),
      .op(op),
      .invA(invA),
      .invB(invB),
      .result(aluOut),
      .zero(zero),
      .ofl(ofl)
   );

   // Set compares see Rt - Rs so a true positive difference means Rs < Rt
   assign lessThan = ~zero & ~(aluOut[15] ^ ofl);

   // Carry out of Rs + Rt rebuilt from the top bits of the sum
   assign carry = (inA[15] & inB[15]) | ((inA[15] | inB[15]) & ~aluOut[15]);

   assign setBit = (sl & lessThan) | (seq & zero) | (sco & carry);
   assign bitRev = {<<{regData1}};

   always_comb begin
      if (sl | seq | sco) begin
         result = {15'b0, setBit};
      end else if (btr) begin
         result = bitRev;
      end else begin
         result = aluOut;
      end
   end

   // Branch tests Rs zero or negative, invB flips the sense
   assign taken = branch & (((seq & (regData1 == '0)) | (sl & regData1[15])) ^ invB);

   // JR and JALR start from Rs, the rest from PC+2
   assign target = ((jump & immCtl) ? regData1 : pcPlus2) + imm;
   assign nextPc = (jump | taken) ? target : pcPlus2;

endmodule

// File: source/wiscCore.sv
/* Single-cycle WISC core without data memory, one instruction per enabled clock
   Load the program only while run is low. HALT holds the PC until reset */
`timescale 1ns/100ps

module wiscCore import wiscPkg::*; #(
   parameter int instrDepthLog2 = wiscPkg::instrDepthLog2
) (
   input  logic                      clk,
   input  logic                      arstN,
   input  logic                      run,
   input  logic                      instrWr,
   input  logic [instrDepthLog2-1:0] instrWrAddr,
   input  word                       instrWrData,
   output word                       pcOut,
   output logic                      wbEn,
   output regIdx                     wbReg,
   output word                       wbData,
   output logic                      halted
);

   word pc, pcPlus2, instr, rdData1, rdData2, imm, exResult, nextPc;
   regIdx rs, rt, rd;
   logic decWbEn, immPres, aluSrc, slbi, btr, sl, seq, sco;
   logic invA, invB, jump, branch, immCtl, link, halt;
   aluOp op;
   logic step;

   assign pcPlus2 = pc + 16'd2;

   // An instruction commits only when running and not halted
   assign step = run & ~halted;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc <= '0;
         halted <= 1'b0;
      end else if (step) begin
         // HALT leaves the PC on its own address
         if (halt) begin
            halted <= 1'b1;
         end else begin
            pc <= nextPc;
         end
      end
   end

   // Fetch by word index
   instrMem #(.instrDepthLog2(instrDepthLog2)) imem (
      .clk(clk),
      .instrWr(instrWr),
      .instrWrAddr(instrWrAddr),
      .instrWrData(instrWrData),
      .rdAddr(pc[instrDepthLog2:1]),
      .rdData(instr)
   );

   decode dec (
      .instr(instr),
      .rs(rs), .rt(rt), .rd(rd),
      .imm(imm),
      .wbEn(decWbEn),
      .immPres(immPres), .aluSrc(aluSrc), .slbi(slbi), .btr(btr),
      .sl(sl), .seq(seq), .sco(sco),
      .invA(invA), .invB(invB),
      .jump(jump), .branch(branch), .immCtl(immCtl),
      .link(link), .halt(halt),
      .op(op)
   );

   regFile regs (
      .clk(clk),
      .arstN(arstN),
      .rdIdx1(rs),
      .rdIdx2(rt),
      .rdData1(rdData1),
      .rdData2(rdData2),
      .wrEn(wbEn),
      .wrIdx(wbReg),
      .wrData(wbData)
   );

   execute exec (
      .regData1(rdData1), .regData2(rdData2), .imm(imm), .pcPlus2(pcPlus2),
      .immPres(immPres), .aluSrc(aluSrc), .slbi(slbi), .btr(btr),
      .sl(sl), .seq(seq), .sco(sco),
      .invA(invA), .invB(invB),
      .jump(jump), .branch(branch), .immCtl(immCtl),
      .op(op),
      .result(exResult),
      .nextPc(nextPc)
   );

   // Write-back, links store the return address
   assign wbEn = step & decWbEn;
   assign wbReg = rd;
   assign wbData = link ? pcPlus2 : exResult;
   assign pcOut = pc;

endmodule

// File: include/isaModel.svh
/* Instruction-level model of the WISC subset for checking the core
   Include inside a module that imports wiscPkg. Unsupported opcodes act as NOP */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Everything one instruction does to the architectural state
typedef struct packed {
   logic  wbEn;
   regIdx wbReg;
   word   wbData;
   word   nextPc;
   logic  halt;
} modelCommit;

// Shift group selected by funct or by the low opcode bits
function automatic word modelShift(word a, logic [3:0] n, logic [1:0] kind);
   case (kind)
      fnRol: return (a << n) | (a >> (5'd16 - n));
      fnSll: return a << n;
      fnRor: return (a >> n) | (a << (5'd16 - n));
      default: return a >> n;
   endcase
endfunction

// Result of executing instr at pc against the register values in regs
function automatic modelCommit modelStep(word instr, word pc, word regs [8]);
   opcode opc;
   word rsV, rtV, pc2, imm5s, imm8s, val, nxt;
   regIdx dst;
   logic we, hlt;
   logic [16:0] wide;
   opc = instr[15:11];
   rsV = regs[instr[10:8]];
   rtV = regs[instr[7:5]];
   pc2 = pc + 16'd2;
   imm5s = {{11{instr[4]}}, instr[4:0]};
   imm8s = {{8{instr[7]}}, instr[7:0]};
   wide = {1'b0, rsV} + {1'b0, rtV};
   dst = (opc[4:3] == 2'b11) ? instr[4:2] : instr[7:5];
   we = 1'b1;
   hlt = 1'b0;
   val = '0;
   nxt = pc2;
   case (opc)
      opAddi: val = rsV + imm5s;
      opSubi: val = imm5s - rsV;
      opXori: val = rsV ^ {11'b0, instr[4:0]};
      opAndni: val = rsV & ~{11'b0, instr[4:0]};
      opRoli, opSlli, opRori, opSrli: val = modelShift(rsV, instr[3:0], opc[1:0]);
      opAlu: begin
         case (instr[1:0])
            fnAdd: val = rsV + rtV;
            fnSub: val = rtV - rsV;
            fnXor: val = rsV ^ rtV;
            default: val = rsV & ~rtV;
         endcase
      end
      opShift: val = modelShift(rsV, rtV[3:0], instr[1:0]);
      opSeq: val = 16'(rsV == rtV);
      opSlt: val = 16'($signed(rsV) < $signed(rtV));
      opSle: val = 16'($signed(rsV) <= $signed(rtV));
      opSco: val = {15'b0, wide[16]};
      opBtr: begin
         // Mirror Rs one bit at a time
         for (int k = 0; k < 16; k++) begin
            val[k] = rsV[15 - k];
         end
      end
      opLbi, opSlbi: begin
         dst = instr[10:8];
         val = (opc == opLbi) ? imm8s : {rsV[7:0], instr[7:0]};
      end
      opBeqz, opBnez, opBltz, opBgez: begin
         we = 1'b0;
         if (opc[1] ? (rsV[15] != opc[0]) : ((rsV == '0) != opc[0])) begin
            nxt = pc2 + imm8s;
         end
      end
      opJ, opJal, opJr, opJalr: begin
         we = opc[1];
         dst = 3'd7;
         val = pc2;
         nxt = opc[0] ? (rsV + imm8s) : (pc2 + {{5{instr[10]}}, instr[10:0]});
      end
      opHalt: begin
         we = 1'b0;
         hlt = 1'b1;
         nxt = pc;
      end
      default: we = 1'b0;
   endcase
   return modelCommit'{we, dst, val, nxt, hlt};
endfunction

`endif

// File: bench/tbWiscCore.sv
/* Random-program testbench for the WISC core, checked against the ISA model
   Programs are 48 words with forward-only control flow and end in HALT */
`timescale 1ns/100ps

module tbWiscCore import wiscPkg::*;;

   `include "isaModel.svh"

   localparam int progLen = 48;
   localparam int numTests = 6;
   localparam int resetCycles = 5;
   localparam int idleCycles = 4;
   localparam int holdCycles = 10;
   // Load, run, reset, idle and hold per test, then a fixed margin
   localparam int cycleLimit =
      numTests * (2 * progLen + resetCycles + idleCycles + holdCycles) + 100;

   logic clk, arstN, run, instrWr;
   logic [instrDepthLog2-1:0] instrWrAddr;
   word instrWrData, pcOut, wbData;
   logic wbEn, halted;
   regIdx wbReg;

   word lfsr;
   word prog [progLen];
   bit isPairJr [progLen];
   word mRegs [8];
   word mPc;
   int errCount, passCount, failCount, commitCount, cycles;

   wiscCore #(.instrDepthLog2(instrDepthLog2)) dut (
      .clk(clk), .arstN(arstN), .run(run),
      .instrWr(instrWr), .instrWrAddr(instrWrAddr), .instrWrData(instrWrData),
      .pcOut(pcOut), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
      .halted(halted)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Watchdog over the whole run
   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycleLimit) begin
         $display("timeout: core never halted");
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   // Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
   function automatic word randBits(input int n);
      word v;
      logic fb;
      v = '0;
      for (int k = 0; k < n; k++) begin
         fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v = {v[14:0], fb};
      end
      return v;
   endfunction

   task automatic checkValue(input string name, input word expected, input word actual);
      if (expected !== actual) begin
         $display("Error: %s expected %h got %h at %0t", name, expected, actual, $time);
         errCount++;
      end
   endtask

   // Forward target word index, never the JR of a LBI/JR pair
   function automatic int pickTarget(input int slot);
      int t;
      t = slot + 1 + (randBits(8) % (progLen - 1 - slot));
      if (isPairJr[t]) t++;
      return t;
   endfunction

   // Mix 0 arithmetic, 1 set compares, 2 control flow
   function automatic opcode pickOpcode(input int mix);
      word n;
      n = randBits(4);
      if (mix == 1) begin
         case (n % 8)
            0: return opSeq;
            1: return opSlt;
            2: return opSle;
            3: return opSco;
            4: return opLbi;
            5: return opSlbi;
            6: return opAlu;
            default: return opSubi;
         endcase
      end
      if (mix == 2) begin
         case (n % 8)
            0: return opBeqz;
            1: return opBnez;
            2: return opBltz;
            3: return opBgez;
            4: return opJ;
            5: return opJal;
            6: return opLbi;
            default: return opAddi;
         endcase
      end
      case (n)
         0, 1: return opAlu;
         2, 3: return opShift;
         4: return opAddi;
         5: return opSubi;
         6: return opXori;
         7: return opAndni;
         8: return opRoli;
         9: return opSlli;
         10: return opRori;
         11: return opSrli;
         12: return opLbi;
         13: return opSlbi;
         14: return opBtr;
         default: return opNop;
      endcase
   endfunction

   // Random fields under the opcode, displacements fixed up afterwards
   function automatic word encode(input opcode opc, input int slot);
      word r, w;
      int t;
      r = randBits(16);
      w = {opc, r[10:0]};
      case (opc)
         opSeq, opSlt, opSle, opSco: begin
            // One compare in four uses the same register twice
            if (r[1:0] == 2'b00) w[7:5] = w[10:8];
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            t = pickTarget(slot);
            w[7:0] = 8'(2 * (t - slot - 1));
         end
         opJ, opJal: begin
            t = pickTarget(slot);
            w[10:0] = 11'(2 * (t - slot - 1));
         end
         default: ;
      endcase
      return w;
   endfunction

   // Built from the end so every forward target already exists
   task automatic genProgram(input int mix);
      int i, t;
      word r;
      for (i = 0; i < progLen; i++) isPairJr[i] = 1'b0;
      prog[progLen-1] = {opHalt, 11'b0};
      i = progLen - 2;
      while (i >= 0) begin
         if (mix == 2 && i >= 1 && randBits(2) == 0) begin
            // LBI loads the address, JR or JALR adds a small even offset
            t = pickTarget(i);
            r = randBits(16);
            prog[i] = {r[0] ? opJalr : opJr, r[10:8], 6'b0, r[1], 1'b0};
            prog[i-1] = {opLbi, r[10:8], 8'(2 * t - 2 * r[1])};
            isPairJr[i] = 1'b1;
            i -= 2;
         end else begin
            prog[i] = encode(pickOpcode(mix), i);
            i--;
         end
      end
   endtask

   task automatic resetCore();
      arstN = 1'b0;
      run = 1'b0;
      instrWr = 1'b0;
      repeat (resetCycles) @(posedge clk);
      #2;
      arstN = 1'b1;
      for (int i = 0; i < 8; i++) mRegs[i] = '0;
      mPc = '0;
      // Run low, so nothing commits and the PC holds
      repeat (idleCycles) begin
         #8;
         checkValue("pcOut", 16'h0, pcOut);
         checkValue("halted", 16'h0, halted);
         checkValue("wbEn", 16'h0, wbEn);
         @(posedge clk);
         #2;
      end
   endtask

   task automatic loadProgram();
      for (int i = 0; i < progLen; i++) begin
         instrWr = 1'b1;
         instrWrAddr = i;
         instrWrData = prog[i];
         @(posedge clk);
         #2;
      end
      instrWr = 1'b0;
   endtask

   // Compare each commit mid-cycle, then step the model after the edge
   task automatic runProgram();
      modelCommit c;
      bit done;
      done = 1'b0;
      commitCount = 0;
      run = 1'b1;
      while (!done) begin
         #8;
         c = modelStep(prog[mPc[6:1]], mPc, mRegs);
         checkValue("wbEn", c.wbEn, wbEn);
         if (c.wbEn) begin
            checkValue("wbReg", c.wbReg, wbReg);
            checkValue("wbData", c.wbData, wbData);
         end
         checkValue("pcOut", mPc, pcOut);
         @(posedge clk);
         #2;
         if (c.wbEn) mRegs[c.wbReg] = c.wbData;
         mPc = c.nextPc;
         done = c.halt;
         commitCount++;
      end
   endtask

   task automatic checkHalt();
      word haltPc;
      haltPc = mPc;
      checkValue("halted", 16'h1, halted);
      repeat (holdCycles) begin
         #8;
         checkValue("pcOut", haltPc, pcOut);
         checkValue("wbEn", 16'h0, wbEn);
         checkValue("halted", 16'h1, halted);
         @(posedge clk);
         #2;
      end
      run = 1'b0;
   endtask

   initial begin
      int errBefore;
      arstN = 1'b0;
      run = 1'b0;
      instrWr = 1'b0;
      instrWrAddr = '0;
      instrWrData = '0;
      lfsr = 16'd57829;
      errCount = 0;
      passCount = 0;
      failCount = 0;
      cycles = 0;
      for (int test = 0; test < numTests; test++) begin
         errBefore = errCount;
         genProgram(test % 3);
         resetCore();
         loadProgram();
         runProgram();
         checkHalt();
         if (errCount == errBefore) begin
            passCount++;
            $display("Test %0d mix %0d: passed, %0d commits", test, test % 3, commitCount);
         end else begin
            failCount++;
            $display("Test %0d mix %0d: failed, %0d errors", test, test % 3,
               errCount - errBefore);
         end
      end
      $display("Tests passed %0d, failed %0d, errors %0d", passCount, failCount, errCount);
      if (failCount == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// File: tb.f
+incdir+include
source/wiscPkg.sv
source/instrMem.sv
source/decode.sv
source/regFile.sv
source/alu.sv
source/execute.sv
source/wiscCore.sv
bench/tbWiscCore.sv
